// File: Bender.yml
package:
  name: sifh

sources:
  - hdl/sifhPkg.sv
  - hdl/binMapper.sv
  - hdl/histogramBuilder.sv
  - hdl/windowCalculator.sv
  - hdl/sifhTop.sv
  - target: test
    files:
      - bench/sifhClockGen.sv
      - bench/sifhTb.sv

// File: bench/sifhClockGen.sv
`timescale 1ns/100ps

module sifhClockGen (
    output logic clk,
    output logic rst
);

    // 8 ns period, toggle every half period
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // reset high for the first 4 rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: bench/sifhStimulus.txt
# H <timestamp> <gap>: one hit, then gap idle cycles; P <pass>: wait for pass, 0 coarse 1 fine
# M <time> <count>: wait for measValid and check measTime and measCount; numbers are decimal
P 0
# meas 1 coarse, 24 hits in bin 9, one hit in 8 other bins
H 600 0 H 601 0 H 602 0 H 603 0 H 604 0 H 605 0 H 606 0 H 607 0
H 600 1 H 601 0 H 602 0 H 603 0 H 604 0 H 605 0 H 606 0 H 607 0
H 600 0 H 601 0 H 602 2 H 603 0 H 604 0 H 605 0 H 606 0 H 607 0
H 100 0 H 200 0 H 300 1 H 400 0 H 500 0 H 700 0 H 800 0 H 900 0
# dropped, builder is no longer collecting
H 604 0 H 604 0 H 604 0
P 1
# meas 1 fine, window 576 to 640, 10 hits in fine bin 7, 18 hits outside
H 604 0 H 605 0 H 606 0 H 607 0 H 648 0 H 648 0 H 648 0 H 648 0
H 604 0 H 605 0 H 606 0 H 607 1 H 540 0 H 540 0 H 540 0 H 580 0
H 648 0 H 648 0 H 648 0 H 648 0 H 590 0 H 620 0 H 630 0 H 604 0
H 605 0 H 540 0 H 540 0 H 540 0 H 648 0 H 648 0 H 648 0 H 648 0
# dropped, would tip the next coarse tie to bin 12
H 800 0 H 800 0 H 800 0
M 606 10
P 0
# meas 2 coarse, tie of 16 between bins 12 and 5
H 800 0 H 801 0 H 802 0 H 803 0 H 800 0 H 801 0 H 802 0 H 803 0
H 800 0 H 801 0 H 802 0 H 803 0 H 800 0 H 801 0 H 802 0 H 803 0
H 350 0 H 351 0 H 352 0 H 353 3 H 350 0 H 351 0 H 352 0 H 353 0
H 350 0 H 351 0 H 352 0 H 353 0 H 350 0 H 351 0 H 352 0 H 353 0
P 1
# meas 2 fine, window 320 to 384, tie of 14 between fine bins 9 and 3
H 356 0 H 357 0 H 358 0 H 359 0 H 356 0 H 357 0 H 358 0 H 359 0
H 356 0 H 357 0 H 358 0 H 359 0 H 356 0 H 357 0 H 332 0 H 333 0
H 334 0 H 335 0 H 332 0 H 333 0 H 334 0 H 335 0 H 332 0 H 333 0
H 334 0 H 335 0 H 332 0 H 333 0 H 321 0 H 321 0 H 321 0 H 321 0
M 334 14
P 0
# meas 3 coarse, peak in bin 0 with 20 hits, 12 hits in bin 15
H 1000 0 H 1001 0 H 1002 0 H 1003 0 H 1000 0 H 1001 0 H 1002 0 H 1003 0
H 1000 0 H 1001 0 H 1002 0 H 1003 0 H 40 0 H 41 0 H 42 0 H 43 0
H 40 0 H 41 0 H 42 0 H 43 0 H 10 0 H 11 0 H 12 0 H 13 0
H 10 0 H 11 0 H 12 0 H 13 0 H 40 0 H 41 0 H 42 0 H 43 0
P 1
# meas 3 fine, window 0 to 64, hits at 350 are outside
H 40 0 H 41 0 H 42 0 H 43 0 H 20 0 H 21 0 H 20 0 H 21 0
H 350 0 H 350 0 H 350 0 H 350 0 H 40 0 H 41 0 H 42 0 H 43 0
H 350 0 H 350 0 H 350 0 H 350 0 H 40 0 H 41 0 H 42 0 H 43 0
H 20 0 H 21 0 H 20 0 H 21 0 H 350 0 H 350 0 H 350 0 H 350 0
M 42 12
P 0

// File: bench/sifhTb.sv
`timescale 1ns/100ps

module sifhTb;
    import sifhPkg::*;

    logic                   clk;
    logic                   rst;
    logic                   wrEn;
    logic [TS_WIDTH-1:0]    roughData;
    pass_t                  pass;
    logic                   measValid;
    logic [TS_WIDTH-1:0]    measTime;
    logic [COUNT_WIDTH-1:0] measCount;

    // error and check counts
    int errors = 0;
    int checks = 0;
    // measValid pulses seen vs M records in the file
    int measPulses = 0;
    int measRecords = 0;
    // cycle budget worked out from the file
    int cycleCount = 0;
    int cycleLimit = 0;

    sifhClockGen clockGenU0 (
        .clk (clk),
        .rst (rst)
    );

    sifhTop dut_i (
        .clk       (clk),
        .rst       (rst),
        .wrEn      (wrEn),
        .roughData (roughData),
        .pass      (pass),
        .measValid (measValid),
        .measTime  (measTime),
        .measCount (measCount)
    );

    function automatic int openStimulus();
        int fd;
        fd = $fopen("bench/sifhStimulus.txt", "r");
        return fd;
    endfunction

    // reads the next record
    // lines starting with # are comments
    // status is 0 at end of file, 1 for a record, 2 if malformed
    task automatic readRecord(input int fd, output logic [7:0] kind,
                              output int argA, output int argB, output int status);
        logic [8*128-1:0] line;
        int code;
        argA = 0;
        argB = 0;
        kind = 8'h00;
        code = $fscanf(fd, " %c", kind);
        while (code == 1 && kind == "#") begin
            code = $fgets(line, fd);
            code = $fscanf(fd, " %c", kind);
        end
        if (code != 1) begin
            status = 0;
        end else if (kind == "P") begin
            status = ($fscanf(fd, "%d", argA) == 1) ? 1 : 2;
        end else if (kind == "H" || kind == "M") begin
            status = ($fscanf(fd, "%d %d", argA, argB) == 2) ? 1 : 2;
        end else begin
            status = 2;
        end
    endtask

    // timeout from total hits, gaps and measurements
    task automatic sizeRun(input int fd);
        logic [7:0] kind;
        int argA;
        int argB;
        int status;
        int hits;
        int gapSum;
        hits   = 0;
        gapSum = 0;
        readRecord(fd, kind, argA, argB, status);
        while (status == 1) begin
            if (kind == "H") begin
                hits++;
                gapSum += argB;
            end else if (kind == "M") begin
                measRecords++;
            end
            readRecord(fd, kind, argA, argB, status);
        end
        cycleLimit = hits * 2 + gapSum + 40 * measRecords;
    endtask

    task automatic waitReset();
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
    endtask

    task automatic checkResetState();
        checks++;
        if (pass !== COARSE) begin
            errors++;
            $display("ERROR pass expected 0x%0h got 0x%0h", COARSE, pass);
        end
        if (measValid !== 1'b0) begin
            errors++;
            $display("ERROR measValid expected 0x0 got 0x%0h", measValid);
        end
    endtask

    // strobe high for one cycle and then gap idle cycles
    task automatic driveHit(input int ts, input int gap);
        @(posedge clk);
        wrEn      <= 1'b1;
        roughData <= ts[TS_WIDTH-1:0];
        repeat (gap) begin
            @(posedge clk);
            wrEn <= 1'b0;
        end
    endtask

    task automatic releaseBus();
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    // idle the strobe until the builder reaches the expected pass
    task automatic waitForPass(input int expPass);
        releaseBus();
        @(negedge clk);
        while (pass !== expPass[0]) begin
            @(negedge clk);
        end
    endtask

    task automatic checkMeasurement(input int expTime, input int expCount);
        releaseBus();
        @(negedge clk);
        while (measValid !== 1'b1) begin
            @(negedge clk);
        end
        checks++;
        if (measTime !== expTime[TS_WIDTH-1:0]) begin
            errors++;
            $display("ERROR measTime expected 0x%0h got 0x%0h", expTime, measTime);
        end
        if (measCount !== expCount[COUNT_WIDTH-1:0]) begin
            errors++;
            $display("ERROR measCount expected 0x%0h got 0x%0h", expCount, measCount);
        end
        // builder is back in the coarse pass by now
        if (pass !== COARSE) begin
            errors++;
            $display("ERROR pass expected 0x%0h got 0x%0h", COARSE, pass);
        end
        // pulse must be one cycle wide
        @(negedge clk);
        if (measValid !== 1'b0) begin
            errors++;
            $display("measValid stayed high for more than one cycle");
        end
    endtask

    task automatic runStimulus(input int fd);
        logic [7:0] kind;
        int argA;
        int argB;
        int status;
        readRecord(fd, kind, argA, argB, status);
        while (status == 1) begin
            case (kind)
                "H": driveHit(argA, argB);
                "P": waitForPass(argA);
                default: checkMeasurement(argA, argB);
            endcase
            readRecord(fd, kind, argA, argB, status);
        end
        if (status == 2) begin
            errors++;
            $display("the stimulus file holds a record that could not be read");
        end
        releaseBus();
    endtask

    task automatic finishRun();
        // extra or missing pulses
        if (measPulses != measRecords) begin
            errors++;
            $display("saw %0d measValid pulses where the file expects %0d",
                     measPulses, measRecords);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    // counts every pulse whether expected or not
    always @(negedge clk) begin
        if (measValid === 1'b1) begin
            measPulses++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            errors++;
            $display("run stopped after %0d cycles without the expected response",
                     cycleLimit);
            finishRun();
        end
    end

    initial begin
        int fd;
        wrEn      = 1'b0;
        roughData = '0;
        fd = openStimulus();
        if (fd == 0) begin
            errors++;
            $display("could not open bench/sifhStimulus.txt");
        end else begin
            // first read only sizes the run
            sizeRun(fd);
            $fclose(fd);
            waitReset();
            checkResetState();
            fd = openStimulus();
            runStimulus(fd);
            $fclose(fd);
        end
        finishRun();
    end

endmodule

// File: filelist.f
hdl/sifhPkg.sv
hdl/binMapper.sv
hdl/histogramBuilder.sv
hdl/windowCalculator.sv
hdl/sifhTop.sv
bench/sifhClockGen.sv
bench/sifhTb.sv

// File: hdl/binMapper.sv
`timescale 1ns/100ps

module binMapper (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wrEn,
    input  logic [sifhPkg::TS_WIDTH-1:0]  roughData,
    input  sifhPkg::pass_t                pass,
    input  sifhPkg::window_t              window,
    output sifhPkg::mappedHit_t           hit
);
    import sifhPkg::*;

    // registered strobe and timestamp
    logic                strobeReg;
    logic [TS_WIDTH-1:0] tsReg;

    // fine window compare
    logic                aboveMin;
    logic                belowMax;
    logic [TS_WIDTH-1:0] offset;

    // strobe delayed by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            strobeReg <= 1'b0;
        end else begin
            strobeReg <= wrEn;
        end
    end

    // timestamp captured on each strobe
    always_ff @(posedge clk) begin
        if (wrEn) begin
            tsReg <= roughData;
        end
    end

    // lower bound inclusive, upper bound exclusive
    assign aboveMin = (tsReg >= window.thMinus);
    assign belowMax = (tsReg < window.thPositive);

    // position inside the fine window
    // only meaningful when the hit is in window
    assign offset = tsReg - window.thMinus;

    always_comb begin
        hit.valid = strobeReg;
        if (pass == COARSE) begin
            // coarse pass covers the whole range
            hit.bin      = tsReg[COARSE_SHIFT +: BIN_WIDTH];
            hit.inWindow = 1'b1;
        end else begin
            // fine pass, 4-code bins from thMinus
            hit.bin      = offset[FINE_SHIFT +: BIN_WIDTH];
            hit.inWindow = aboveMin && belowMax;
        end
    end

endmodule

// File: hdl/histogramBuilder.sv
`timescale 1ns/100ps

module histogramBuilder (
    input  logic                 clk,
    input  logic                 rst,
    input  sifhPkg::mappedHit_t  hit,
    output sifhPkg::pass_t       pass,
    output logic                 peakDone,
    output sifhPkg::peakResult_t peak
);
    import sifhPkg::*;

    builderState_t state;
    builderState_t stateNext;

    // one saturating counter per bin
    logic [COUNT_WIDTH-1:0] binCount [NUM_BINS];

    // accepted hits in the current pass
    logic [HIT_CNT_WIDTH-1:0] hitCount;

    // peak search
    logic [BIN_WIDTH-1:0]   scanIdx;
    logic [BIN_WIDTH-1:0]   maxBin;
    logic [COUNT_WIDTH-1:0] maxCount;

    logic hitAccept;
    logic lastHit;
    logic scanLast;
    logic binFull;

    // hits only count while collecting
    assign hitAccept = hit.valid && (state == COLLECT);
    assign lastHit   = (hitCount == HIT_CNT_WIDTH'(ACQ_HITS - 1));
    assign scanLast  = (scanIdx == BIN_WIDTH'(NUM_BINS - 1));

    // counter of the incoming bin already at max
    assign binFull = (binCount[hit.bin] == COUNT_WIDTH'(COUNT_MAX));

    // next state
    always_comb begin
        stateNext = state;
        case (state)
            COLLECT: begin
                // 32nd accepted hit ends the pass
                if (hitAccept && lastHit) begin
                    stateNext = SETTLE;
                end
            end
            SETTLE: begin
                // last increment lands here
                stateNext = SCAN;
            end
            SCAN: begin
                if (scanLast) begin
                    stateNext = REPORT;
                end
            end
            REPORT: begin
                stateNext = COLLECT;
            end
            default: begin
                stateNext = COLLECT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= COLLECT;
        end else begin
            state <= stateNext;
        end
    end

    // pass flips at the end of report
    // so window and pass change together
    always_ff @(posedge clk) begin
        if (rst) begin
            pass <= COARSE;
        end else if (state == REPORT) begin
            pass <= (pass == COARSE) ? FINE : COARSE;
        end
    end

    // accepted hit counter
    always_ff @(posedge clk) begin
        if (rst) begin
            hitCount <= '0;
        end else if (hitAccept) begin
            if (lastHit) begin
                hitCount <= '0;
            end else begin
                hitCount <= hitCount + 1'b1;
            end
        end
    end

    // bin counters
    // out-of-window hits are counted above but never binned
    always_ff @(posedge clk) begin
        if (rst || (state == REPORT)) begin
            for (int i = 0; i < NUM_BINS; i++) begin
                binCount[i] <= '0;
            end
        end else if (hitAccept && hit.inWindow && !binFull) begin
            binCount[hit.bin] <= binCount[hit.bin] + 1'b1;
        end
    end

    // scan index, one bin per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            scanIdx <= '0;
        end else if (state == SETTLE) begin
            scanIdx <= '0;
        end else if (state == SCAN) begin
            scanIdx <= scanIdx + 1'b1;
        end
    end

    // running maximum
    // strict compare, so lowest index wins a tie
    always_ff @(posedge clk) begin
        if (state == SETTLE) begin
            maxBin   <= '0;
            maxCount <= '0;
        end else if (state == SCAN) begin
            if (binCount[scanIdx] > maxCount) begin
                maxBin   <= scanIdx;
                maxCount <= binCount[scanIdx];
            end
        end
    end

    // result valid during report only
    assign peakDone   = (state == REPORT);
    assign peak.pass  = pass;
    assign peak.bin   = maxBin;
    assign peak.count = maxCount;

endmodule

// File: hdl/sifhPkg.sv
package sifhPkg;

    // raw timestamp and bin sizes
    localparam int TS_WIDTH = 10;
    localparam int TS_MAX = 2 ** TS_WIDTH - 1;
    localparam int BIN_WIDTH = 4;
    localparam int NUM_BINS = 16;

    // bin counters saturate at COUNT_MAX
    localparam int COUNT_WIDTH = 8;
    localparam int COUNT_MAX = 2 ** COUNT_WIDTH - 1;

    // coarse bin is 64 codes wide, fine bin is 4 codes wide
    localparam int COARSE_SHIFT = 6;
    localparam int FINE_SHIFT = 2;
    // offset from a fine bin start to its centre
    localparam int FINE_HALF = 2 ** (FINE_SHIFT - 1);
    localparam int WINDOW_SPAN = 64;

    // accepted hits per pass
    localparam int ACQ_HITS = 32;
    localparam int HIT_CNT_WIDTH = $clog2(ACQ_HITS);

    // which histogram is being built (hisNum)
    typedef enum logic {
        COARSE = 1'b0,
        FINE   = 1'b1
    } pass_t;

    typedef enum logic [1:0] {
        COLLECT,
        SETTLE,
        SCAN,
        REPORT
    } builderState_t;

    typedef struct packed {
        logic                 valid;
        logic [BIN_WIDTH-1:0] bin;
        logic                 inWindow;
    } mappedHit_t;

    // thPositive is exclusive
    typedef struct packed {
        logic [TS_WIDTH-1:0] thMinus;
        logic [TS_WIDTH-1:0] thPositive;
    } window_t;

    typedef struct packed {
        pass_t                  pass;
        logic [BIN_WIDTH-1:0]   bin;
        logic [COUNT_WIDTH-1:0] count;
    } peakResult_t;

endpackage

// File: hdl/sifhTop.sv
`timescale 1ns/100ps

module sifhTop (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wrEn,
    input  logic [sifhPkg::TS_WIDTH-1:0]    roughData,
    output sifhPkg::pass_t                  pass,
    output logic                            measValid,
    output logic [sifhPkg::TS_WIDTH-1:0]    measTime,
    output logic [sifhPkg::COUNT_WIDTH-1:0] measCount
);
    import sifhPkg::*;

    // mapper to builder
    mappedHit_t  hit;

    // builder to calculator
    logic        peakDone;
    peakResult_t peak;

    // calculator back to mapper
    window_t     window;

    // input side, timestamp to bin
    binMapper binMapperU0 (
        .clk       (clk),
        .rst       (rst),
        .wrEn      (wrEn),
        .roughData (roughData),
        .pass      (pass),
        .window    (window),
        .hit       (hit)
    );

    // histogram and peak search
    histogramBuilder histogramBuilderU0 (
        .clk      (clk),
        .rst      (rst),
        .hit      (hit),
        .pass     (pass),
        .peakDone (peakDone),
        .peak     (peak)
    );

    // algebraic block, window and time estimate
    windowCalculator windowCalculatorU0 (
        .clk       (clk),
        .rst       (rst),
        .peakDone  (peakDone),
        .peak      (peak),
        .window    (window),
        .measValid (measValid),
        .measTime  (measTime),
        .measCount (measCount)
    );

endmodule

// File: hdl/windowCalculator.sv
`timescale 1ns/100ps

module windowCalculator (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            peakDone,
    input  sifhPkg::peakResult_t            peak,
    output sifhPkg::window_t                window,
    output logic                            measValid,
    output logic [sifhPkg::TS_WIDTH-1:0]    measTime,
    output logic [sifhPkg::COUNT_WIDTH-1:0] measCount
);
    import sifhPkg::*;

    // start of the winning coarse bin
    logic [TS_WIDTH-1:0] coarseBase;
    // one extra bit to catch the top-bin overflow
    logic [TS_WIDTH:0]   upperSum;
    // fine bin centre relative to thMinus
    logic [TS_WIDTH-1:0] fineOffset;

    logic coarseDone;
    logic fineDone;

    assign coarseDone = peakDone && (peak.pass == COARSE);
    assign fineDone   = peakDone && (peak.pass == FINE);

    assign coarseBase = TS_WIDTH'(peak.bin) << COARSE_SHIFT;
    assign upperSum   = {1'b0, coarseBase} + (TS_WIDTH + 1)'(WINDOW_SPAN);
    assign fineOffset = (TS_WIDTH'(peak.bin) << FINE_SHIFT) + TS_WIDTH'(FINE_HALF);

    // threshold pair for the fine pass
    always_ff @(posedge clk) begin
        if (rst) begin
            window <= '0;
        end else if (coarseDone) begin
            window.thMinus <= coarseBase;
            // bin 15 would wrap to 0
            if (upperSum[TS_WIDTH]) begin
                window.thPositive <= TS_WIDTH'(TS_MAX);
            end else begin
                window.thPositive <= upperSum[TS_WIDTH-1:0];
            end
        end
    end

    // one pulse per finished measurement
    always_ff @(posedge clk) begin
        if (rst) begin
            measValid <= 1'b0;
        end else begin
            measValid <= fineDone;
        end
    end

    // time estimate and peak height
    always_ff @(posedge clk) begin
        if (fineDone) begin
            measTime  <= window.thMinus + fineOffset;
            measCount <= peak.count;
        end
    end

endmodule
